//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_mm_ram
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "simulation reported an error, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
logic/mm_pkg.sv
logic/mm_addr_decode.sv
logic/mm_dp_ram.sv
logic/mm_timer.sv
logic/mm_data_resp.sv
logic/mm_ram_top.sv
dv/mm_ram_properties.sv
dv/tb_mm_ram.sv

//--- dv/mm_ram_properties.sv
// Handshake and address map assertions
`timescale 1ns/1ps

module mm_ram_properties #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              data_req_i,
    input mm_pkg::data_req_t req_i,
    input logic              data_gnt_o,
    input logic              data_rvalid_o,
    input logic              instr_req_i,
    input logic              instr_rvalid_o
);

    logic addr_mapped;

    // RAM range plus the four register words
    assign addr_mapped = ((req_i.addr >> RAM_ADDR_WIDTH) == 0)
                      || (req_i.addr == mm_pkg::ADDR_STATUS)
                      || (req_i.addr == mm_pkg::ADDR_EXIT)
                      || (req_i.addr == mm_pkg::ADDR_TIMER_MASK)
                      || (req_i.addr == mm_pkg::ADDR_TIMER_CNT);

    gnt_same_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o == data_req_i)
        else $error("data grant differs from the data request");

    data_rvalid_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o == $past(data_req_i))
        else $error("data rvalid does not follow the request by one cycle");

    instr_rvalid_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_o == $past(instr_req_i))
        else $error("instr rvalid does not follow the request by one cycle");

    write_in_map: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (data_req_i && req_i.we) |-> addr_mapped)
        else $error("data write to unmapped address %h", req_i.addr);

endmodule

bind mm_ram_top mm_ram_properties #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
) props0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .req_i          (data_req),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .instr_req_i    (instr_req_i),
    .instr_rvalid_o (instr_rvalid_o)
);

//--- dv/tb_mm_ram.sv
// Memory-mapped RAM wrapper testbench
`timescale 1ns/1ps

module tb_mm_ram;

    localparam int RAM_AW   = 12;
    localparam int IW       = 128;
    localparam int IB_OFF   = $clog2(IW / 8);
    localparam int N_INIT   = (2**RAM_AW) / 4;
    localparam int N_RAND   = 300;
    localparam int N_FETCH  = 150;
    localparam int N_DECODE = 60;
    localparam int N_TIMER  = 9;
    // one timer trial counts as 50 operations, it waits up to 45 cycles
    localparam int TOTAL_OPS  = N_INIT + 2 * N_RAND + N_FETCH + N_DECODE + 50 * N_TIMER;
    localparam int MAX_CYCLES = 4 * TOTAL_OPS + 200;

    logic              clk_i;
    logic              rst_ni;
    logic              instr_req_i;
    logic [RAM_AW-1:0] instr_addr_i;
    logic              instr_gnt_o;
    logic              instr_rvalid_o;
    logic [IW-1:0]     instr_rdata_o;
    logic              data_req_i;
    logic [31:0]       data_addr_i;
    logic              data_we_i;
    logic [3:0]        data_be_i;
    logic [31:0]       data_wdata_i;
    logic              data_gnt_o;
    logic              data_rvalid_o;
    logic [31:0]       data_rdata_o;
    logic [4:0]        irq_id_i;
    logic              irq_ack_i;
    logic              irq_timer_o;
    logic              tests_passed_o;
    logic              tests_failed_o;
    logic              exit_valid_o;
    logic [31:0]       exit_value_o;

    logic [7:0]  shadow [2**RAM_AW];
    logic [31:0] m_mask;
    logic [31:0] m_cnt;
    logic        m_irq;
    logic        tmr_mask_we;
    logic        tmr_cnt_we;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    mm_ram_top #(
        .RAM_ADDR_WIDTH    (RAM_AW),
        .INSTR_RDATA_WIDTH (IW)
    ) dut0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .irq_timer_o    (irq_timer_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("errors: %0d, checks: %0d", errors + 1, checks);
            $display("Verification failed");
            $finish;
        end
    end

    // timer model, written from the register rules
    assign tmr_mask_we = data_req_i && data_we_i && (data_addr_i == mm_pkg::ADDR_TIMER_MASK);
    assign tmr_cnt_we  = data_req_i && data_we_i && (data_addr_i == mm_pkg::ADDR_TIMER_CNT);

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_mask <= '0;
            m_cnt  <= '0;
            m_irq  <= 1'b0;
        end else if (tmr_cnt_we) begin
            m_cnt <= data_wdata_i;
        end else if (tmr_mask_we) begin
            m_mask <= data_wdata_i;
        end else begin
            if (m_cnt != 0)
                m_cnt <= m_cnt - 1;
            if (irq_ack_i && irq_id_i == mm_pkg::TIMER_IRQ_ID)
                m_irq <= 1'b0;
            else if (m_cnt == 1 && m_mask[mm_pkg::TIMER_IRQ_ID])
                m_irq <= 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni && irq_timer_o !== m_irq) begin
            errors++;
            $display("Fail irq_timer_o expected %h got %h at %0t", m_irq, irq_timer_o, $time);
        end
    end

    task automatic check32(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check1(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] w;
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = shadow[{addr[RAM_AW-1:2], 2'(i)}];
        return w;
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic data_op(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata);
        logic is_status;
        logic is_exit;
        is_status    = we && (addr == mm_pkg::ADDR_STATUS);
        is_exit      = we && (addr == mm_pkg::ADDR_EXIT);
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
        #1;
        check1("data_gnt_o", 1'b1, data_gnt_o);
        check1("tests_passed_o", is_status && wdata == mm_pkg::PASS_MAGIC, tests_passed_o);
        check1("tests_failed_o", is_status && wdata == mm_pkg::FAIL_MAGIC, tests_failed_o);
        check1("exit_valid_o", is_exit, exit_valid_o);
        if (is_exit)
            check32("exit_value_o", wdata, exit_value_o);
        @(posedge clk_i);
        #1;
        if (data_rvalid_o !== 1'b1) begin
            errors++;
            $display("data rvalid missing one cycle after the request to %h", addr);
        end else if (!we) begin
            check32("data_rdata_o", exp_rdata, data_rdata_o);
        end
        #1;
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
    endtask

    task automatic idle_cycle();
        #1;
        check1("tests_passed_o", 1'b0, tests_passed_o);
        check1("tests_failed_o", 1'b0, tests_failed_o);
        check1("exit_valid_o", 1'b0, exit_valid_o);
        @(posedge clk_i);
        #1;
        check1("data_rvalid_o", 1'b0, data_rvalid_o);
        check1("instr_rvalid_o", 1'b0, instr_rvalid_o);
        #1;
    endtask

    task automatic ram_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        data_op(addr, 1'b1, be, wdata, 32'h0);
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                shadow[{addr[RAM_AW-1:2], 2'(i)}] = wdata[8*i +: 8];
        end
    endtask

    task automatic fetch(input logic [RAM_AW-1:0] addr);
        logic [IW-1:0] exp;
        for (int i = 0; i < IW / 8; i++)
            exp[8*i +: 8] = shadow[{addr[RAM_AW-1:IB_OFF], IB_OFF'(i)}];
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        #1;
        check1("instr_gnt_o", 1'b1, instr_gnt_o);
        @(posedge clk_i);
        #1;
        checks++;
        if (instr_rvalid_o !== 1'b1) begin
            errors++;
            $display("instr rvalid missing one cycle after the fetch of %h", addr);
        end else if (instr_rdata_o !== exp) begin
            errors++;
            $display("Fail instr_rdata_o expected %h got %h", exp, instr_rdata_o);
        end
        #1;
        instr_req_i = 1'b0;
    endtask

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] a;
        do begin
            a = $urandom;
        end while ((a >> RAM_AW) == 0 || a == mm_pkg::ADDR_STATUS || a == mm_pkg::ADDR_EXIT
                   || a == mm_pkg::ADDR_TIMER_MASK || a == mm_pkg::ADDR_TIMER_CNT);
        return a;
    endfunction

    task automatic timer_trial(input logic irq_on);
        int n;
        int k;
        n = $urandom_range(40, 1);
        if (irq_on)
            data_op(mm_pkg::ADDR_TIMER_MASK, 1'b1, 4'hf, 32'h1 << mm_pkg::TIMER_IRQ_ID, 0);
        else
            data_op(mm_pkg::ADDR_TIMER_MASK, 1'b1, 4'hf,
                    $urandom & ~(32'h1 << mm_pkg::TIMER_IRQ_ID), 0);
        data_op(mm_pkg::ADDR_TIMER_CNT, 1'b1, 4'hf, n, 0);
        k = 0;
        do begin
            @(posedge clk_i);
            #1;
            k++;
        end while (irq_timer_o !== 1'b1 && k < n + 5);
        #1;
        if (irq_on) begin
            check32("irq_timer_rise_cycles", n, k);
            // an ack for some other source leaves the timer irq alone
            irq_ack_i = 1'b1;
            irq_id_i  = 5'($urandom_range(31, 8));
            @(posedge clk_i);
            #1;
            check1("irq_timer_o", 1'b1, irq_timer_o);
            #1;
            irq_id_i = mm_pkg::TIMER_IRQ_ID;
            @(posedge clk_i);
            #1;
            check1("irq_timer_o", 1'b0, irq_timer_o);
            #1;
            irq_ack_i = 1'b0;
        end else begin
            check1("irq_timer_o", 1'b0, irq_timer_o);
        end
    endtask

    initial begin
        logic [31:0] a;
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        void'($urandom(32'h2244_f655));
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // give every RAM byte a known value
        for (int w = 0; w < N_INIT; w++)
            ram_write(w * 4, 4'hf, $urandom);

        for (int i = 0; i < N_RAND; i++) begin
            ram_write($urandom_range(2**RAM_AW - 1, 0), 4'($urandom), $urandom);
            if ($urandom_range(3, 0) == 0)
                idle_cycle();
        end
        for (int i = 0; i < N_RAND; i++) begin
            a = $urandom_range(2**RAM_AW - 1, 0);
            data_op(a, 1'b0, 4'($urandom), $urandom, shadow_word(a));
            if ($urandom_range(3, 0) == 0)
                idle_cycle();
        end

        for (int i = 0; i < N_FETCH; i++) begin
            fetch(RAM_AW'($urandom));
            if ($urandom_range(2, 0) == 0)
                idle_cycle();
        end

        // status, exit and zero reads outside the RAM
        for (int i = 0; i < N_DECODE; i++) begin
            case ($urandom_range(8, 0))
                0: data_op(mm_pkg::ADDR_STATUS, 1'b1, 4'hf, mm_pkg::PASS_MAGIC, 0);
                1: data_op(mm_pkg::ADDR_STATUS, 1'b1, 4'hf, mm_pkg::FAIL_MAGIC, 0);
                2: data_op(mm_pkg::ADDR_STATUS, 1'b1, 4'hf, $urandom | 32'h8000_0000, 0);
                3: data_op(mm_pkg::ADDR_EXIT, 1'b1, 4'hf, $urandom, 0);
                4: data_op(unmapped_addr(), 1'b0, 4'hf, 0, 0);
                5: data_op(mm_pkg::ADDR_STATUS, 1'b0, 4'hf, 0, 0);
                6: data_op(mm_pkg::ADDR_EXIT, 1'b0, 4'hf, 0, 0);
                7: data_op(mm_pkg::ADDR_TIMER_MASK, 1'b0, 4'hf, 0, 0);
                default: data_op(mm_pkg::ADDR_TIMER_CNT, 1'b0, 4'hf, 0, 0);
            endcase
            if ($urandom_range(3, 0) == 0)
                idle_cycle();
        end

        for (int i = 0; i < N_TIMER; i++)
            timer_trial(i % 3 != 2);
        idle_cycle();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- logic/mm_addr_decode.sv
// Data request address decoder
`timescale 1ns/1ps

module mm_addr_decode #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic                data_req_i,
    input  mm_pkg::data_req_t   req_i,
    output mm_pkg::ram_req_t    ram_req_o,
    output mm_pkg::timer_wr_t   timer_wr_o,
    output mm_pkg::rdata_sel_e  rdata_sel_o,
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output logic [31:0]         exit_value_o
);

    logic in_ram;
    logic wr;

    // everything below 2^RAM_ADDR_WIDTH belongs to the RAM
    assign in_ram = (req_i.addr[31:RAM_ADDR_WIDTH] == '0);
    assign wr     = data_req_i & req_i.we;

    // RAM request, payload passed straight through
    always_comb begin
        ram_req_o.req   = data_req_i & in_ram;
        ram_req_o.addr  = req_i.addr;
        ram_req_o.we    = req_i.we;
        ram_req_o.be    = req_i.be;
        ram_req_o.wdata = req_i.wdata;
    end

    // timer register writes
    always_comb begin
        timer_wr_o.mask_we = wr && (req_i.addr == mm_pkg::ADDR_TIMER_MASK);
        timer_wr_o.cnt_we  = wr && (req_i.addr == mm_pkg::ADDR_TIMER_CNT);
        timer_wr_o.wdata   = req_i.wdata;
    end

    // status outputs last only for the cycle of the write
    always_comb begin
        tests_passed_o = 1'b0;
        tests_failed_o = 1'b0;
        exit_valid_o   = 1'b0;
        exit_value_o   = '0;

        if (wr && (req_i.addr == mm_pkg::ADDR_STATUS)) begin
            // any other value is ignored
            if (req_i.wdata == mm_pkg::PASS_MAGIC) begin
                tests_passed_o = 1'b1;
            end else if (req_i.wdata == mm_pkg::FAIL_MAGIC) begin
                tests_failed_o = 1'b1;
            end
        end

        if (wr && (req_i.addr == mm_pkg::ADDR_EXIT)) begin
            exit_valid_o = 1'b1;
            exit_value_o = req_i.wdata;
        end
    end

    // timer, status and unmapped reads all return zero
    assign rdata_sel_o = in_ram ? mm_pkg::SEL_RAM : mm_pkg::SEL_ZERO;

endmodule

//--- logic/mm_data_resp.sv
// Data port response stage
`timescale 1ns/1ps

module mm_data_resp (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               data_req_i,
    input  mm_pkg::rdata_sel_e rdata_sel_i,
    input  logic [31:0]        ram_rdata_i,
    output logic               data_gnt_o,
    output logic               data_rvalid_o,
    output logic [31:0]        data_rdata_o
);

    logic               rvalid_q;
    mm_pkg::rdata_sel_e sel_q;

    // no back-pressure, every target answers in one cycle
    assign data_gnt_o = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            sel_q    <= mm_pkg::SEL_ZERO;
        end else begin
            rvalid_q <= data_req_i;
            // only update on a request, keeps the last select otherwise
            if (data_req_i) begin
                sel_q <= rdata_sel_i;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;

    // read mux
    always_comb begin
        if (sel_q == mm_pkg::SEL_RAM) begin
            data_rdata_o = ram_rdata_i;
        end else begin
            data_rdata_o = '0;
        end
    end

endmodule

//--- logic/mm_dp_ram.sv
// Dual-port byte RAM
`timescale 1ns/1ps

module mm_dp_ram #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  mm_pkg::ram_req_t             ram_req_i,
    output logic [31:0]                  data_rdata_o
);

    localparam int INSTR_BYTES = INSTR_RDATA_WIDTH / 8;
    localparam int INSTR_OFF   = $clog2(INSTR_BYTES);

    logic [7:0] mem [2**RAM_ADDR_WIDTH];

    logic [RAM_ADDR_WIDTH-INSTR_OFF-1:0] instr_blk;
    logic [RAM_ADDR_WIDTH-3:0]           data_word;

    // block and word indices, aligned down
    assign instr_blk = instr_addr_i[RAM_ADDR_WIDTH-1:INSTR_OFF];
    assign data_word = ram_req_i.addr[RAM_ADDR_WIDTH-1:2];

    // instruction port, lowest address ends up in the lowest byte
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[{instr_blk, INSTR_OFF'(i)}];
            end
        end
    end

    // data port
    always_ff @(posedge clk_i) begin
        if (ram_req_i.req) begin
            for (int i = 0; i < 4; i++) begin
                // read returns the word as it was before this edge
                data_rdata_o[8*i +: 8] <= mem[{data_word, 2'(i)}];
                if (ram_req_i.we && ram_req_i.be[i]) begin
                    mem[{data_word, 2'(i)}] <= ram_req_i.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- logic/mm_pkg.sv
// Memory-mapped RAM wrapper definitions

package mm_pkg;

    // timer registers
    localparam logic [31:0] ADDR_TIMER_MASK = 32'h1500_0000;
    localparam logic [31:0] ADDR_TIMER_CNT  = 32'h1500_0004;

    // test status registers
    localparam logic [31:0] ADDR_STATUS = 32'h2000_0000;
    localparam logic [31:0] ADDR_EXIT   = 32'h2000_0004;

    // values written to ADDR_STATUS
    localparam logic [31:0] PASS_MAGIC = 32'd123456789;
    localparam logic [31:0] FAIL_MAGIC = 32'd1;

    // mask bit and interrupt id of the timer
    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    // one data request as issued by the core
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } data_req_t;

    // data port request into the RAM
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } ram_req_t;

    // timer register write strobes
    typedef struct packed {
        logic        mask_we;
        logic        cnt_we;
        logic [31:0] wdata;
    } timer_wr_t;

    // source of the data read word
    typedef enum logic [1:0] {
        SEL_RAM  = 2'd0,
        SEL_ZERO = 2'd1
    } rdata_sel_e;

endpackage

//--- logic/mm_ram_top.sv
// Memory-mapped RAM wrapper top
`timescale 1ns/1ps

module mm_ram_top #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    input  logic                         data_req_i,
    input  logic [31:0]                  data_addr_i,
    input  logic                         data_we_i,
    input  logic [3:0]                   data_be_i,
    input  logic [31:0]                  data_wdata_i,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output logic [31:0]                  data_rdata_o,

    input  logic [4:0]                   irq_id_i,
    input  logic                         irq_ack_i,
    output logic                         irq_timer_o,

    output logic                         tests_passed_o,
    output logic                         tests_failed_o,
    output logic                         exit_valid_o,
    output logic [31:0]                  exit_value_o
);

    mm_pkg::data_req_t  data_req;
    mm_pkg::ram_req_t   ram_req;
    mm_pkg::timer_wr_t  timer_wr;
    mm_pkg::rdata_sel_e rdata_sel;
    logic [31:0]        ram_rdata;
    logic               instr_rvalid_q;

    always_comb begin
        data_req.addr  = data_addr_i;
        data_req.we    = data_we_i;
        data_req.be    = data_be_i;
        data_req.wdata = data_wdata_i;
    end

    // instruction handshake, always granted
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;

    mm_addr_decode #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) decode0 (
        .data_req_i     (data_req_i),
        .req_i          (data_req),
        .ram_req_o      (ram_req),
        .timer_wr_o     (timer_wr),
        .rdata_sel_o    (rdata_sel),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    mm_dp_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) ram0 (
        .clk_i         (clk_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .ram_req_i     (ram_req),
        .data_rdata_o  (ram_rdata)
    );

    mm_timer timer0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .timer_wr_i  (timer_wr),
        .irq_id_i    (irq_id_i),
        .irq_ack_i   (irq_ack_i),
        .irq_timer_o (irq_timer_o)
    );

    mm_data_resp resp0 (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .rdata_sel_i   (rdata_sel),
        .ram_rdata_i   (ram_rdata),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

endmodule

//--- logic/mm_timer.sv
// Countdown timer with interrupt
`timescale 1ns/1ps

module mm_timer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  mm_pkg::timer_wr_t timer_wr_i,
    input  logic [4:0]        irq_id_i,
    input  logic              irq_ack_i,
    output logic              irq_timer_o
);

    logic [31:0] mask_q;
    logic [31:0] cnt_q;
    logic        irq_q;
    logic        any_wr;
    logic        ack;

    assign any_wr = timer_wr_i.mask_we | timer_wr_i.cnt_we;
    assign ack    = irq_ack_i && (irq_id_i == mm_pkg::TIMER_IRQ_ID);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
        end else if (timer_wr_i.mask_we) begin
            mask_q <= timer_wr_i.wdata;
        end
    end

    // count and interrupt hold while a timer register is written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
            irq_q <= 1'b0;
        end else if (timer_wr_i.cnt_we) begin
            cnt_q <= timer_wr_i.wdata;
        end else if (!any_wr) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 32'd1;
            end
            // fires on the 1 -> 0 step
            if (cnt_q == 32'd1 && mask_q[mm_pkg::TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end
            // ack wins over a set in the same cycle
            if (ack) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_timer_o = irq_q;

endmodule
